// File: hw/core_config.svh
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// datapath
`define CORE_XLEN       32
`define CORE_NUM_ALU    3

// queue and register file sizes
`define CORE_IQ_DEPTH   8
`define CORE_PHYS_REGS  64  // sets tag width

// completion
`define CORE_WB_DEPTH   8

`endif

// File: hw/isa_pkg.sv
`include "core_config.svh"

package isa_pkg;

    typedef logic [`CORE_XLEN-1:0] word_t;

    // integer alu functions
    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        AND  = 4'd2,
        OR   = 4'd3,
        XOR  = 4'd4,
        SLL  = 4'd5,
        SRL  = 4'd6,
        SRA  = 4'd7,  // arithmetic, sign fill
        SLT  = 4'd8,
        SLTU = 4'd9
    } alu_op_e;

endpackage

// File: hw/core_pkg.sv
`include "core_config.svh"

package core_pkg;

    // physical register tag
    typedef logic [$clog2(`CORE_PHYS_REGS)-1:0] phys_tag_t;

    // issue queue slot
    typedef logic [$clog2(`CORE_IQ_DEPTH)-1:0] iq_idx_t;

    typedef logic [`CORE_NUM_ALU-1:0] alu_mask_t;  // bit k is alu k

endpackage

// File: hw/issue_queue.sv
`timescale 1ns/1ps
`include "core_config.svh"

module issue_queue (
    input  logic                clk,
    input  logic                rstn,
    input  logic                dispatch_valid,
    input  isa_pkg::alu_op_e    dispatch_op,
    input  isa_pkg::word_t      dispatch_pc,
    input  core_pkg::phys_tag_t src1_tag,
    input  core_pkg::phys_tag_t src2_tag,
    input  logic                src1_ready,
    input  logic                src2_ready,
    input  isa_pkg::word_t      src1_value,
    input  isa_pkg::word_t      src2_value,
    input  isa_pkg::word_t      imm,
    input  logic                use_imm,
    input  core_pkg::phys_tag_t dest_tag,
    input  core_pkg::alu_mask_t wake_valid,
    input  core_pkg::phys_tag_t wake_tag [`CORE_NUM_ALU],
    input  isa_pkg::word_t      wake_data [`CORE_NUM_ALU],
    input  logic                wb_room,
    output logic                iq_full,
    output core_pkg::alu_mask_t issue_valid,
    output isa_pkg::alu_op_e    issue_op [`CORE_NUM_ALU],
    output isa_pkg::word_t      issue_a [`CORE_NUM_ALU],
    output isa_pkg::word_t      issue_b [`CORE_NUM_ALU],
    output core_pkg::phys_tag_t issue_tag [`CORE_NUM_ALU],
    output isa_pkg::word_t      issue_pc [`CORE_NUM_ALU]
);
    import isa_pkg::*;
    import core_pkg::*;

    localparam int DEPTH = `CORE_IQ_DEPTH;
    localparam int NALU  = `CORE_NUM_ALU;

    logic [DEPTH-1:0] valid;
    alu_op_e          ent_op [DEPTH];
    word_t            ent_pc [DEPTH];
    phys_tag_t        ent_dst [DEPTH];
    phys_tag_t        ent_a_tag [DEPTH];
    phys_tag_t        ent_b_tag [DEPTH];
    logic [DEPTH-1:0] ent_a_rdy;
    logic [DEPTH-1:0] ent_b_rdy;
    word_t            ent_a_val [DEPTH];
    word_t            ent_b_val [DEPTH];

    // operand state after this cycle's broadcast
    logic [DEPTH-1:0] a_rdy;
    logic [DEPTH-1:0] b_rdy;
    word_t            a_val [DEPTH];
    word_t            b_val [DEPTH];

    logic             d_a_rdy;
    logic             d_b_rdy;
    word_t            d_a_val;
    word_t            d_b_val;
    logic             accept;
    iq_idx_t          free_idx;
    iq_idx_t          issue_slot [NALU];
    logic [DEPTH-1:0] issue_sel;
    logic             slot_clash;

    // look for a waiting tag on the result bus
    function automatic void snoop(input phys_tag_t tag, input logic rdy_in, input word_t val_in,
                                  output logic rdy, output word_t val);
        rdy = rdy_in;
        val = val_in;
        for (int k = 0; k < NALU; k++) begin
            if (!rdy_in && wake_valid[k] && wake_tag[k] == tag) begin
                rdy = 1'b1;
                val = wake_data[k];
            end
        end
    endfunction

    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            snoop(ent_a_tag[i], ent_a_rdy[i], ent_a_val[i], a_rdy[i], a_val[i]);
            snoop(ent_b_tag[i], ent_b_rdy[i], ent_b_val[i], b_rdy[i], b_val[i]);
        end
    end

    // immediate replaces operand b
    always_comb begin
        snoop(src1_tag, src1_ready, src1_value, d_a_rdy, d_a_val);
        snoop(src2_tag, src2_ready | use_imm, use_imm ? imm : src2_value, d_b_rdy, d_b_val);
    end

    assign iq_full = &valid;
    assign accept  = dispatch_valid && !iq_full;

    always_comb begin
        free_idx = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (!valid[i]) free_idx = iq_idx_t'(i);  // lowest free wins
        end
    end

    // k-th ready entry goes to alu k
    always_comb begin
        int n;
        n           = 0;
        issue_valid = '0;
        issue_sel   = '0;
        for (int k = 0; k < NALU; k++) issue_slot[k] = '0;
        for (int i = 0; i < DEPTH; i++) begin
            if (wb_room && valid[i] && a_rdy[i] && b_rdy[i] && n < NALU) begin
                issue_valid[n] = 1'b1;
                issue_slot[n]  = iq_idx_t'(i);
                issue_sel[i]   = 1'b1;
                n++;
            end
        end
    end

    always_comb begin
        for (int k = 0; k < NALU; k++) begin
            issue_op[k]  = ent_op[issue_slot[k]];
            issue_a[k]   = a_val[issue_slot[k]];
            issue_b[k]   = b_val[issue_slot[k]];
            issue_tag[k] = ent_dst[issue_slot[k]];
            issue_pc[k]  = ent_pc[issue_slot[k]];
        end
    end

    // two granted alus reading one entry
    always_comb begin
        slot_clash = 1'b0;
        for (int j = 0; j < NALU; j++) begin
            for (int k = j + 1; k < NALU; k++) begin
                if (issue_valid[j] && issue_valid[k] && issue_slot[j] == issue_slot[k])
                    slot_clash = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid <= '0;
        end else begin
            valid <= (valid & ~issue_sel) | (DEPTH'(accept) << free_idx);
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < DEPTH; i++) begin
            ent_a_rdy[i] <= a_rdy[i];
            ent_a_val[i] <= a_val[i];
            ent_b_rdy[i] <= b_rdy[i];
            ent_b_val[i] <= b_val[i];
        end
        if (accept) begin
            ent_op[free_idx]    <= dispatch_op;
            ent_pc[free_idx]    <= dispatch_pc;
            ent_dst[free_idx]   <= dest_tag;
            ent_a_tag[free_idx] <= src1_tag;
            ent_b_tag[free_idx] <= src2_tag;
            ent_a_rdy[free_idx] <= d_a_rdy;
            ent_a_val[free_idx] <= d_a_val;
            ent_b_rdy[free_idx] <= d_b_rdy;
            ent_b_val[free_idx] <= d_b_val;
        end
    end

    a_no_dispatch_full: assert property (@(posedge clk) disable iff (!rstn)
        dispatch_valid |-> !iq_full)
        else $error("dispatch while issue queue full");

    a_unique_slot: assert property (@(posedge clk) disable iff (!rstn)
        !slot_clash)
        else $error("two alus share one queue slot");

endmodule

// File: hw/int_alu.sv
`timescale 1ns/1ps
`include "core_config.svh"

module int_alu (
    input  logic                clk,
    input  logic                rstn,
    input  logic                issue_valid,
    input  isa_pkg::alu_op_e    op,
    input  isa_pkg::word_t      a,
    input  isa_pkg::word_t      b,
    input  core_pkg::phys_tag_t tag,
    input  isa_pkg::word_t      pc,
    output logic                res_valid,
    output core_pkg::phys_tag_t res_tag,
    output isa_pkg::word_t      res_data,
    output isa_pkg::word_t      res_pc
);
    import isa_pkg::*;

    localparam int SHW = $clog2(`CORE_XLEN);

    word_t result;

    always_comb begin
        case (op)
            ADD:     result = a + b;
            SUB:     result = a - b;
            AND:     result = a & b;
            OR:      result = a | b;
            XOR:     result = a ^ b;
            SLL:     result = a << b[SHW-1:0];
            SRL:     result = a >> b[SHW-1:0];
            SRA:     result = word_t'($signed(a) >>> b[SHW-1:0]);
            SLT:     result = word_t'($signed(a) < $signed(b));
            SLTU:    result = word_t'(a < b);
            default: result = '0;  // unused encodings
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            res_tag  <= tag;
            res_data <= result;
            res_pc   <= pc;
        end
    end

endmodule

// File: hw/writeback_arbiter.sv
`timescale 1ns/1ps
`include "core_config.svh"

module writeback_arbiter (
    input  logic                clk,
    input  logic                rstn,
    input  core_pkg::alu_mask_t res_valid,
    input  core_pkg::phys_tag_t res_tag [`CORE_NUM_ALU],
    input  isa_pkg::word_t      res_data [`CORE_NUM_ALU],
    input  isa_pkg::word_t      res_pc [`CORE_NUM_ALU],
    output logic                wb_room,
    output logic                wb_valid,
    output core_pkg::phys_tag_t wb_tag,
    output isa_pkg::word_t      wb_data,
    output isa_pkg::word_t      wb_pc
);
    import isa_pkg::*;
    import core_pkg::*;

    localparam int DEPTH = `CORE_WB_DEPTH;
    localparam int NALU  = `CORE_NUM_ALU;
    localparam int PW    = $clog2(DEPTH);
    localparam int CW    = $clog2(DEPTH + 1);

    phys_tag_t      mem_tag [DEPTH];
    word_t          mem_data [DEPTH];
    word_t          mem_pc [DEPTH];
    logic [PW-1:0]  wr_ptr;
    logic [PW-1:0]  rd_ptr;
    logic [CW-1:0]  count;
    logic [CW-1:0]  n_push;
    logic [PW-1:0]  push_slot [NALU];
    logic           pop;

    assign n_push = CW'($countones(res_valid));
    assign pop    = (count != '0);

    // leave room for a full issue group behind what is already arriving
    assign wb_room = (count + n_push) <= CW'(DEPTH - NALU);

    // lower alu index takes the earlier slot
    always_comb begin
        logic [PW-1:0] p;
        p = wr_ptr;
        for (int k = 0; k < NALU; k++) begin
            push_slot[k] = p;
            if (res_valid[k]) p = p + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        for (int k = 0; k < NALU; k++) begin
            if (res_valid[k]) begin
                mem_tag[push_slot[k]]  <= res_tag[k];
                mem_data[push_slot[k]] <= res_data[k];
                mem_pc[push_slot[k]]   <= res_pc[k];
            end
        end
        if (pop) begin
            wb_tag  <= mem_tag[rd_ptr];
            wb_data <= mem_data[rd_ptr];
            wb_pc   <= mem_pc[rd_ptr];
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            wb_valid <= 1'b0;
        end else begin
            wr_ptr   <= wr_ptr + PW'(n_push);  // wraps since depth is a power of two
            rd_ptr   <= rd_ptr + PW'(pop);
            count    <= count + n_push - CW'(pop);
            wb_valid <= pop;
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (!rstn)
        count + n_push <= DEPTH)
        else $error("writeback fifo overflow");

    // pointers must show a stored entry behind every pop
    a_no_empty_pop: assert property (@(posedge clk) disable iff (!rstn)
        wb_valid |-> $past(rd_ptr) != $past(wr_ptr) || $past(count) == CW'(DEPTH))
        else $error("writeback from empty fifo");

endmodule

// File: hw/exec_core.sv
`timescale 1ns/1ps
`include "core_config.svh"

module exec_core (
    input  logic                clk,
    input  logic                rstn,
    input  logic                dispatch_valid,
    input  isa_pkg::alu_op_e    dispatch_op,
    input  isa_pkg::word_t      dispatch_pc,
    input  core_pkg::phys_tag_t src1_tag,
    input  core_pkg::phys_tag_t src2_tag,
    input  logic                src1_ready,
    input  logic                src2_ready,
    input  isa_pkg::word_t      src1_value,
    input  isa_pkg::word_t      src2_value,
    input  isa_pkg::word_t      imm,
    input  logic                use_imm,
    input  core_pkg::phys_tag_t dest_tag,
    output logic                iq_full,
    output logic                wb_valid,
    output core_pkg::phys_tag_t wb_tag,
    output isa_pkg::word_t      wb_data,
    output isa_pkg::word_t      wb_pc
);
    import isa_pkg::*;
    import core_pkg::*;

    alu_mask_t issue_valid;
    alu_op_e   issue_op [`CORE_NUM_ALU];
    word_t     issue_a [`CORE_NUM_ALU];
    word_t     issue_b [`CORE_NUM_ALU];
    phys_tag_t issue_tag [`CORE_NUM_ALU];
    word_t     issue_pc [`CORE_NUM_ALU];

    // result bus, also the wakeup bus
    alu_mask_t res_valid;
    phys_tag_t res_tag [`CORE_NUM_ALU];
    word_t     res_data [`CORE_NUM_ALU];
    word_t     res_pc [`CORE_NUM_ALU];
    logic      wb_room;

    issue_queue iq_i (
        .clk            (clk),
        .rstn           (rstn),
        .dispatch_valid (dispatch_valid),
        .dispatch_op    (dispatch_op),
        .dispatch_pc    (dispatch_pc),
        .src1_tag       (src1_tag),
        .src2_tag       (src2_tag),
        .src1_ready     (src1_ready),
        .src2_ready     (src2_ready),
        .src1_value     (src1_value),
        .src2_value     (src2_value),
        .imm            (imm),
        .use_imm        (use_imm),
        .dest_tag       (dest_tag),
        .wake_valid     (res_valid),
        .wake_tag       (res_tag),
        .wake_data      (res_data),
        .wb_room        (wb_room),
        .iq_full        (iq_full),
        .issue_valid    (issue_valid),
        .issue_op       (issue_op),
        .issue_a        (issue_a),
        .issue_b        (issue_b),
        .issue_tag      (issue_tag),
        .issue_pc       (issue_pc)
    );

    for (genvar k = 0; k < `CORE_NUM_ALU; k++) begin : alu_gen
        int_alu alu_i (
            .clk         (clk),
            .rstn        (rstn),
            .issue_valid (issue_valid[k]),
            .op          (issue_op[k]),
            .a           (issue_a[k]),
            .b           (issue_b[k]),
            .tag         (issue_tag[k]),
            .pc          (issue_pc[k]),
            .res_valid   (res_valid[k]),
            .res_tag     (res_tag[k]),
            .res_data    (res_data[k]),
            .res_pc      (res_pc[k])
        );
    end

    writeback_arbiter wb_i (
        .clk       (clk),
        .rstn      (rstn),
        .res_valid (res_valid),
        .res_tag   (res_tag),
        .res_data  (res_data),
        .res_pc    (res_pc),
        .wb_room   (wb_room),
        .wb_valid  (wb_valid),
        .wb_tag    (wb_tag),
        .wb_data   (wb_data),
        .wb_pc     (wb_pc)
    );

endmodule

// File: tb/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rstn
);
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;  // 10 ns period
    end

    initial begin
        rstn = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);  // release away from the active edge
        rstn = 1'b1;
    end

endmodule

// File: tb/exec_core_tb.sv
`timescale 1ns/1ps
`include "core_config.svh"

module exec_core_tb;
    import isa_pkg::*;
    import core_pkg::*;

    localparam int    TIMEOUT_CYCLES = 4000;  // roughly ten times a normal run
    localparam word_t SIGN_BIT       = 32'h8000_0000;
    localparam word_t ONES           = 32'hffff_ffff;

    // one operation as the dispatcher sees it
    typedef struct packed {
        alu_op_e   op;
        logic      r1;
        phys_tag_t t1;
        word_t     v1;
        logic      r2;
        phys_tag_t t2;
        word_t     v2;
        logic      ui;
        word_t     imm;
        phys_tag_t dst;
        word_t     pc;
    } op_rec_t;

    logic      clk;
    logic      rstn;
    logic      dispatch_valid;
    alu_op_e   dispatch_op;
    word_t     dispatch_pc;
    phys_tag_t src1_tag;
    phys_tag_t src2_tag;
    logic      src1_ready;
    logic      src2_ready;
    word_t     src1_value;
    word_t     src2_value;
    word_t     imm;
    logic      use_imm;
    phys_tag_t dest_tag;
    logic      iq_full;
    logic      wb_valid;
    phys_tag_t wb_tag;
    word_t     wb_data;
    word_t     wb_pc;

    // scoreboard by tag
    logic  sb_busy [`CORE_PHYS_REGS];
    word_t sb_data [`CORE_PHYS_REGS];
    word_t sb_pc [`CORE_PHYS_REGS];
    int    n_booked = 0;
    int    n_done   = 0;
    int    cycles   = 0;
    word_t next_pc  = 32'h0000_1000;
    logic [31:0] rng_state = 32'h073e5a4a;

    tb_clock_gen clock_i (
        .clk  (clk),
        .rstn (rstn)
    );

    exec_core dut_i (
        .clk            (clk),
        .rstn           (rstn),
        .dispatch_valid (dispatch_valid),
        .dispatch_op    (dispatch_op),
        .dispatch_pc    (dispatch_pc),
        .src1_tag       (src1_tag),
        .src2_tag       (src2_tag),
        .src1_ready     (src1_ready),
        .src2_ready     (src2_ready),
        .src1_value     (src1_value),
        .src2_value     (src2_value),
        .imm            (imm),
        .use_imm        (use_imm),
        .dest_tag       (dest_tag),
        .iq_full        (iq_full),
        .wb_valid       (wb_valid),
        .wb_tag         (wb_tag),
        .wb_data        (wb_data),
        .wb_pc          (wb_pc)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [31:0] rand32();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // expected alu result with shifts on b[4:0]
    function automatic word_t alu_ref(input alu_op_e op, input word_t a, input word_t b);
        logic [4:0] sh;
        word_t      fill;
        sh   = b[4:0];
        fill = a[31] ? ~(ONES >> sh) : '0;
        case (op)
            ADD:     return a + b;
            SUB:     return a + ~b + 1'b1;
            AND:     return a & b;
            OR:      return a | b;
            XOR:     return a ^ b;
            SLL:     return a << sh;
            SRL:     return a >> sh;
            SRA:     return (a >> sh) | fill;
            SLT:     return word_t'((a ^ SIGN_BIT) < (b ^ SIGN_BIT));
            SLTU:    return word_t'(a < b);
            default: return '0;
        endcase
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp)
            abort_run($sformatf("error at %0t: %s is %h, expected %h", $time, name, got, exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            abort_run($sformatf("error at %0t: %s is %b, expected %b", $time, name, got, exp));
    endtask

    task automatic check_tag(input phys_tag_t tag);
        if ($isunknown(tag))
            abort_run($sformatf("writeback at %0t carries an unknown tag", $time));
        else if (!sb_busy[tag])
            abort_run($sformatf("writeback at %0t with tag %0d that is not in flight", $time, tag));
    endtask

    task automatic random_op(output op_rec_t r);
        word_t x;
        x     = rand32();
        r.op  = alu_op_e'(4'(x % 10));
        r.ui  = x[8];
        r.r1  = 1'b1;
        r.t1  = phys_tag_t'(x >> 16);  // ignored while ready
        r.v1  = rand32();
        r.r2  = 1'b1;
        r.t2  = phys_tag_t'(x >> 24);
        r.v2  = rand32();
        r.imm = rand32();
        r.dst = '0;
        r.pc  = '0;
    endtask

    // give the op a free tag and a pc, enter its expected result
    task automatic book(inout op_rec_t r);
        phys_tag_t t;
        word_t     a;
        word_t     b;
        t = phys_tag_t'(rand32());
        repeat (`CORE_PHYS_REGS) begin
            if (sb_busy[t]) t = t + 1'b1;
        end
        if (sb_busy[t]) abort_run("no free tag left for a new operation");
        a = r.r1 ? r.v1 : sb_data[r.t1];  // producer's expected value
        b = r.ui ? r.imm : (r.r2 ? r.v2 : sb_data[r.t2]);
        r.dst = t;
        r.pc  = next_pc;
        next_pc = next_pc + 4;
        sb_busy[t] = 1'b1;
        sb_data[t] = alu_ref(r.op, a, b);
        sb_pc[t]   = r.pc;
        n_booked++;
    endtask

    // called on a falling edge, returns on the next one
    task automatic send(input op_rec_t r);
        while (iq_full) @(negedge clk);
        dispatch_op    = r.op;
        dispatch_pc    = r.pc;
        src1_tag       = r.t1;
        src1_ready     = r.r1;
        src1_value     = r.v1;
        src2_tag       = r.t2;
        src2_ready     = r.r2;
        src2_value     = r.v2;
        imm            = r.imm;
        use_imm        = r.ui;
        dest_tag       = r.dst;
        dispatch_valid = 1'b1;
        @(negedge clk);
        dispatch_valid = 1'b0;
    endtask

    task automatic drain();
        while (n_done != n_booked) @(negedge clk);
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES)
            abort_run($sformatf("timeout after %0d cycles with %0d of %0d operations written back",
                                cycles, n_done, n_booked));
    end

    // writeback compare
    always @(negedge clk) begin
        if (rstn && wb_valid) begin
            check_tag(wb_tag);
            check_word("wb_data", wb_data, sb_data[wb_tag]);
            check_word("wb_pc", wb_pc, sb_pc[wb_tag]);
            sb_busy[wb_tag] = 1'b0;
            n_done++;
        end
    end

    initial begin
        op_rec_t r;
        op_rec_t p;
        op_rec_t q;
        op_rec_t pend;
        logic    pend_on;
        int      waiters;
        int      left;
        dispatch_valid = 1'b0;
        dispatch_op    = ADD;
        dispatch_pc    = '0;
        src1_tag       = '0;
        src2_tag       = '0;
        src1_ready     = 1'b0;
        src2_ready     = 1'b0;
        src1_value     = '0;
        src2_value     = '0;
        imm            = '0;
        use_imm        = 1'b0;
        dest_tag       = '0;
        for (int t = 0; t < `CORE_PHYS_REGS; t++) begin
            sb_busy[t] = 1'b0;
        end
        @(posedge rstn);
        @(negedge clk);
        check_bit("iq_full", iq_full, 1'b0);
        check_bit("wb_valid", wb_valid, 1'b0);

        // every op, register and immediate form
        for (int i = 0; i < 10; i++) begin
            for (int m = 0; m < 2; m++) begin
                random_op(r);
                r.op = alu_op_e'(i);
                r.ui = (m == 1);
                book(r);
                send(r);
            end
        end
        drain();

        // chains dispatched tail first
        for (int i = 0; i < 4; i++) begin
            random_op(p);
            book(p);
            random_op(q);
            q.r1 = 1'b0;
            q.t1 = p.dst;
            book(q);
            random_op(r);
            r.ui = 1'b0;
            r.r2 = 1'b0;
            r.t2 = q.dst;  // wakes through src2
            book(r);
            send(r);
            send(q);
            random_op(r);
            r.ui = 1'b0;
            r.r1 = 1'b0;
            r.r2 = 1'b0;
            r.t1 = p.dst;
            r.t2 = p.dst;
            book(r);
            send(r);
            send(p);
        end
        drain();

        // seven waiters, then the producer fills the queue
        random_op(p);
        book(p);
        for (int i = 0; i < 7; i++) begin
            random_op(r);
            r.r1 = 1'b0;
            r.t1 = p.dst;
            book(r);
            send(r);
            check_bit("iq_full", iq_full, 1'b0);
        end
        send(p);
        check_bit("iq_full", iq_full, 1'b1);
        drain();

        // random stress, one deferred producer at a time
        pend_on = 1'b0;
        waiters = 0;
        for (int n = 0; n < 300; n++) begin
            if (pend_on && (waiters >= 5 || rand32() % 4 == 0)) begin
                send(pend);
                pend_on = 1'b0;
            end else begin
                if (!pend_on && rand32() % 4 == 0) begin
                    random_op(pend);
                    book(pend);
                    pend_on = 1'b1;
                    waiters = 0;
                end
                random_op(r);
                if (pend_on && rand32() % 3 == 0) begin
                    r.r1 = 1'b0;
                    r.t1 = pend.dst;
                end
                if (pend_on && !r.ui && rand32() % 3 == 0) begin
                    r.r2 = 1'b0;
                    r.t2 = pend.dst;
                end
                if (!r.r1 || !r.r2) waiters++;
                book(r);
                send(r);
            end
        end
        if (pend_on) send(pend);
        drain();
        repeat (2 * `CORE_WB_DEPTH) @(negedge clk);  // a repeated writeback would land here

        left = 0;
        for (int t = 0; t < `CORE_PHYS_REGS; t++) begin
            if (sb_busy[t]) left++;
        end
        if (left == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            abort_run($sformatf("scoreboard still holds %0d operations at the end", left));
        end
    end

endmodule

// File: project.f
+incdir+hw
hw/isa_pkg.sv
hw/core_pkg.sv
hw/issue_queue.sv
hw/int_alu.sv
hw/writeback_arbiter.sv
hw/exec_core.sv
tb/tb_clock_gen.sv
tb/exec_core_tb.sv

// File: run.sh
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal -f project.f \
    --top-module exec_core_tb -o exec_core_sim \
    && ./obj_dir/exec_core_sim \
    || exit 1
